//--- src.f
verilog/usbPePkg.sv
verilog/usbTokenCapture.sv
verilog/usbTransactionFsm.sv
verilog/usbTxSequencer.sv
verilog/usbProtocolEngine.sv
verif/usbPeTb.sv

//--- verif/usbPeTb.sv
`default_nettype none

module usbPeTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [usbPePkg::devAddrWidth-1:0] devAddr = 7'd5;
    localparam int epCount = 3;
    localparam int maxPacketSize = 8;
    localparam int responseTimeout = 200;

    // PID bytes as they appear on the wire
    localparam logic [7:0] ackByte = 8'hd2;
    localparam logic [7:0] nakByte = 8'h5a;
    localparam logic [7:0] data0Byte = 8'hc3;
    localparam logic [7:0] data1Byte = 8'h4b;

    // Worst case of each test in clock cycles
    localparam int resetCycles = 4;
    localparam int ignoreWorst = 3 * 40;
    localparam int outWorst = 150;
    localparam int badOutWorst = 100;
    localparam int inWorst = 200;
    localparam int capWorst = responseTimeout + 200;
    localparam int nakWorst = 100;
    localparam int cycleLimit = resetCycles + ignoreWorst + outWorst + badOutWorst
        + inWorst + capWorst + nakWorst + 300;

    logic clk12;
    logic rstN;
    usbPePkg::rxStream_t rxIn;
    logic rxAccept;
    usbPePkg::txStream_t txOut;
    logic txAccept;
    logic txDoneSending;
    logic [usbPePkg::endpWidth-1:0] epSelect;
    logic epTransStart;
    logic epOutValid;
    logic [7:0] epOutData;
    logic epOutFull;
    usbPePkg::epInByte_t epIn;
    logic epInPop;
    usbPePkg::epResponse_t epResp;
    usbPePkg::transResult_t fillResult;
    usbPePkg::transResult_t popResult;

    integer seed = 74;
    int errorCount = 0;
    int cycleCount = 0;
    int doneDelay = 0;

    // Host packet bytes, endpoint IN queue, captured traffic
    logic [7:0] hostBytes[$];
    logic [7:0] inBytes[$];
    logic [7:0] txData[$];
    logic txLast[$];
    logic [7:0] outData[$];
    logic [7:0] expTx[$];
    logic expLast[$];

    // Endpoint answer for the next transaction
    logic [usbPePkg::pidWidth-1:0] respPid;
    logic respIsHandshake;

    // Event counters
    int startCount = 0;
    int reqCount = 0;
    int txDoneCount = 0;
    int fillCount = 0;
    int popCount = 0;
    logic fillSuccess = 1'b0;
    logic popSuccess = 1'b0;
    int popDoneTxDones = 0;

    usbProtocolEngine #(
        .devAddr(devAddr),
        .epCount(epCount),
        .maxPacketSize(maxPacketSize),
        .responseTimeout(responseTimeout)
    ) DUT (
        .clk12_i(clk12),
        .rstN_i(rstN),
        .rx_i(rxIn),
        .rxAccept_o(rxAccept),
        .tx_o(txOut),
        .txAccept_i(txAccept),
        .txDoneSending_i(txDoneSending),
        .epSelect_o(epSelect),
        .epTransStart_o(epTransStart),
        .epOutValid_o(epOutValid),
        .epOutData_o(epOutData),
        .epOutFull_i(epOutFull),
        .epIn_i(epIn),
        .epInPop_o(epInPop),
        .epResp_i(epResp),
        .fillResult_o(fillResult),
        .popResult_o(popResult)
    );

    always #50 clk12 = ~clk12;

    // ======================================================================
    // Serializer, endpoint and traffic monitor
    // ======================================================================

    // Random stalls and a done pulse two cycles after the last byte
    always @(posedge clk12) begin
        if (!rstN) begin
            txAccept <= 1'b0;
            txDoneSending <= 1'b0;
            doneDelay = 0;
        end else begin
            txDoneSending <= doneDelay == 1;
            if (doneDelay > 0) begin
                doneDelay = doneDelay - 1;
            end
            if (txOut.valid && txAccept && txOut.last) begin
                doneDelay = 2;
            end
            txAccept <= ($random(seed) & 3) != 0;
        end
    end

    // Endpoint buffer head and response
    always @(posedge clk12) begin
        if (!rstN) begin
            epResp <= '0;
            epIn <= '0;
        end else begin
            if (epInPop && inBytes.size() > 0) begin
                inBytes.delete(0);
            end
            if (inBytes.size() > 0) begin
                epIn.data <= inBytes[0];
                epIn.available <= 1'b1;
                epIn.isLast <= inBytes.size() == 1;
            end else begin
                epIn <= '0;
            end
            // Answer once the transaction starts and withdraw once used
            if (epTransStart) begin
                epResp.valid <= 1'b1;
                epResp.isHandshake <= respIsHandshake;
                epResp.pidUpper <= respPid[3:2];
            end else if (txOut.reqSend || popResult.done
                    || (fillResult.done && !fillResult.success)) begin
                epResp.valid <= 1'b0;
            end
        end
    end

    always @(posedge clk12) begin
        if (rstN) begin
            if (epTransStart) begin
                startCount <= startCount + 1;
            end
            if (txOut.reqSend) begin
                reqCount <= reqCount + 1;
            end
            if (txOut.valid && txAccept) begin
                txData.push_back(txOut.data);
                txLast.push_back(txOut.last);
            end
            if (epOutValid) begin
                outData.push_back(epOutData);
            end
            if (txDoneSending) begin
                txDoneCount <= txDoneCount + 1;
            end
            if (fillResult.done) begin
                fillCount <= fillCount + 1;
                fillSuccess <= fillResult.success;
            end
            if (popResult.done) begin
                popCount <= popCount + 1;
                popSuccess <= popResult.success;
                // Serializer done pulses seen up to this strobe
                popDoneTxDones <= txDoneCount + (txDoneSending ? 1 : 0);
            end
        end
    end

    always @(posedge clk12) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "watchdog stopped the run");
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
            input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t ns: %s: got 0x%0h, expected 0x%0h",
                $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // PID in the low nibble with its complement on top
    function automatic logic [7:0] pidByte(input logic [3:0] pid);
        return {~pid, pid};
    endfunction

    // CRC5 field left zero, keep carries the front end's CRC verdict
    task automatic loadToken(input logic [3:0] pid, input logic [6:0] addr,
            input logic [3:0] endp);
        hostBytes.delete();
        hostBytes.push_back(pidByte(pid));
        hostBytes.push_back({endp[0], addr});
        hostBytes.push_back({5'b0, endp[3:1]});
    endtask

    // Host sends hostBytes honouring rxAccept, then done and a gap
    task automatic sendPacket(input logic keepFlag);
        int idx;
        idx = 0;
        while (idx < hostBytes.size()) begin
            rxIn.valid <= 1'b1;
            rxIn.data <= hostBytes[idx];
            @(posedge clk12);
            if (rxAccept) begin
                idx++;
            end
        end
        rxIn.valid <= 1'b0;
        rxIn.done <= 1'b1;
        rxIn.keep <= keepFlag;
        @(posedge clk12);
        rxIn.done <= 1'b0;
        repeat (4) @(posedge clk12);
    endtask

    task automatic checkTxPacket(input string what);
        int idx;
        checkEqual(txData.size(), expTx.size(), {what, " byte count"});
        for (idx = 0; idx < expTx.size(); idx++) begin
            checkEqual(txData[idx], expTx[idx], {what, " byte"});
            checkEqual(txLast[idx], expLast[idx], {what, " last flag"});
        end
    endtask

    task automatic clearCaptures();
        txData.delete();
        txLast.delete();
        outData.delete();
        expTx.delete();
        expLast.delete();
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic ignoreForeignTokens();
        int startBefore;
        int reqBefore;
        startBefore = startCount;
        reqBefore = reqCount;
        // Another device
        loadToken(usbPePkg::pidOut, 7'd6, 4'd0);
        sendPacket(1'b1);
        // First endpoint number past the count
        loadToken(usbPePkg::pidIn, devAddr, 4'(epCount));
        sendPacket(1'b1);
        // Front end flags a bad CRC
        loadToken(usbPePkg::pidSetup, devAddr, 4'd0);
        sendPacket(1'b0);
        repeat (6) @(posedge clk12);
        checkEqual(startCount, startBefore, "transaction start on a foreign token");
        checkEqual(reqCount, reqBefore, "tx request on a foreign token");
    endtask

    task automatic outTransfer();
        int fillBefore;
        int doneBefore;
        clearCaptures();
        respPid = usbPePkg::pidAck;
        respIsHandshake = 1'b1;
        fillBefore = fillCount;
        doneBefore = txDoneCount;
        loadToken(usbPePkg::pidOut, devAddr, 4'd1);
        sendPacket(1'b1);
        hostBytes = '{pidByte(usbPePkg::pidData0), 8'h11, 8'h22, 8'h33, 8'h44};
        sendPacket(1'b1);
        while (fillCount == fillBefore) @(posedge clk12);
        checkEqual(fillSuccess, 1'b1, "OUT fill success");
        checkEqual(epSelect, 4'd1, "OUT endpoint select");
        while (txDoneCount == doneBefore) @(posedge clk12);
        repeat (5) @(posedge clk12);
        checkEqual(outData.size(), 4, "OUT byte count at endpoint");
        checkEqual(outData[0], 8'h11, "OUT byte 0");
        checkEqual(outData[1], 8'h22, "OUT byte 1");
        checkEqual(outData[2], 8'h33, "OUT byte 2");
        checkEqual(outData[3], 8'h44, "OUT byte 3");
        expTx.push_back(ackByte);
        expLast.push_back(1'b1);
        checkTxPacket("OUT handshake");
    endtask

    task automatic outBadData();
        int fillBefore;
        int reqBefore;
        clearCaptures();
        respPid = usbPePkg::pidAck;
        respIsHandshake = 1'b1;
        fillBefore = fillCount;
        reqBefore = reqCount;
        loadToken(usbPePkg::pidOut, devAddr, 4'd0);
        sendPacket(1'b1);
        hostBytes = '{pidByte(usbPePkg::pidData1), 8'h5a, 8'ha5};
        sendPacket(1'b0);
        while (fillCount == fillBefore) @(posedge clk12);
        checkEqual(fillSuccess, 1'b0, "bad OUT fill success");
        repeat (20) @(posedge clk12);
        checkEqual(reqCount, reqBefore, "tx request after bad OUT data");
        checkEqual(txData.size(), 0, "bytes sent after bad OUT data");
    endtask

    task automatic inTransfer();
        int popBefore;
        int doneBefore;
        int idx;
        clearCaptures();
        respPid = usbPePkg::pidData1;
        respIsHandshake = 1'b0;
        expTx.push_back(data1Byte);
        expLast.push_back(1'b0);
        for (idx = 0; idx < 5; idx++) begin
            inBytes.push_back(8'ha0 + 8'(idx));
            expTx.push_back(8'ha0 + 8'(idx));
            expLast.push_back(idx == 4);
        end
        popBefore = popCount;
        doneBefore = txDoneCount;
        repeat (2) @(posedge clk12);
        loadToken(usbPePkg::pidIn, devAddr, 4'd2);
        sendPacket(1'b1);
        while (txDoneCount == doneBefore) @(posedge clk12);
        checkTxPacket("IN data packet");
        // Host acknowledges
        hostBytes = '{pidByte(usbPePkg::pidAck)};
        sendPacket(1'b1);
        while (popCount == popBefore) @(posedge clk12);
        checkEqual(popSuccess, 1'b1, "IN pop success after ACK");
        checkEqual(inBytes.size(), 0, "IN bytes left at endpoint");
        repeat (5) @(posedge clk12);
    endtask

    task automatic inCappedBySize();
        int popBefore;
        int doneBefore;
        int idx;
        clearCaptures();
        respPid = usbPePkg::pidData0;
        respIsHandshake = 1'b0;
        expTx.push_back(data0Byte);
        expLast.push_back(1'b0);
        for (idx = 0; idx < 12; idx++) begin
            // Distinct value per queue slot
            inBytes.push_back(8'(8'h3c + idx * 7));
            // Only the first maxPacketSize bytes go out
            if (idx < maxPacketSize) begin
                expTx.push_back(8'(8'h3c + idx * 7));
                expLast.push_back(idx == maxPacketSize - 1);
            end
        end
        popBefore = popCount;
        doneBefore = txDoneCount;
        repeat (2) @(posedge clk12);
        loadToken(usbPePkg::pidIn, devAddr, 4'd1);
        sendPacket(1'b1);
        while (txDoneCount == doneBefore) @(posedge clk12);
        checkTxPacket("IN capped packet");
        // No ACK from the host, wait for the response timer
        while (popCount == popBefore) @(posedge clk12);
        checkEqual(popSuccess, 1'b0, "IN pop success without ACK");
        checkEqual(inBytes.size(), 12 - maxPacketSize, "IN bytes left after cap");
        inBytes.delete();
        repeat (5) @(posedge clk12);
    endtask

    task automatic inHandshakeReply();
        int popBefore;
        int doneBefore;
        clearCaptures();
        respPid = usbPePkg::pidNak;
        respIsHandshake = 1'b1;
        // Queued data must stay put behind a NAK
        inBytes.push_back(8'h77);
        inBytes.push_back(8'h88);
        popBefore = popCount;
        doneBefore = txDoneCount;
        repeat (2) @(posedge clk12);
        loadToken(usbPePkg::pidIn, devAddr, 4'd0);
        sendPacket(1'b1);
        while (popCount == popBefore) @(posedge clk12);
        checkEqual(popSuccess, 1'b0, "IN pop success on NAK");
        checkEqual(popDoneTxDones, doneBefore + 1, "NAK pop strobe before tx done");
        expTx.push_back(nakByte);
        expLast.push_back(1'b1);
        checkTxPacket("IN NAK handshake");
        checkEqual(inBytes.size(), 2, "IN bytes left after NAK");
        inBytes.delete();
        repeat (5) @(posedge clk12);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        clk12 = 1'b0;
        rstN = 1'b0;
        rxIn = '0;
        txAccept = 1'b0;
        txDoneSending = 1'b0;
        epOutFull = 1'b0;
        epIn = '0;
        epResp = '0;
        respPid = usbPePkg::pidAck;
        respIsHandshake = 1'b1;

        repeat (resetCycles) @(posedge clk12);
        rstN <= 1'b1;
        repeat (2) @(posedge clk12);

        // Quiet outputs straight after reset
        checkEqual(txOut.valid, 1'b0, "tx valid after reset");
        checkEqual(txOut.reqSend, 1'b0, "tx request after reset");
        checkEqual(epTransStart, 1'b0, "transaction start after reset");
        checkEqual(epOutValid, 1'b0, "OUT valid after reset");
        checkEqual(epInPop, 1'b0, "IN pop after reset");
        checkEqual(fillResult.done, 1'b0, "fill result after reset");
        checkEqual(popResult.done, 1'b0, "pop result after reset");

        ignoreForeignTokens();
        outTransfer();
        outBadData();
        inTransfer();
        inCappedBySize();
        inHandshakeReply();

        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/usbProtocolEngine.sv
`default_nettype none

module usbProtocolEngine #(
    parameter logic [usbPePkg::devAddrWidth-1:0] devAddr = '0,
    parameter int epCount = 1,
    parameter int maxPacketSize = 64,
    parameter int responseTimeout = 200
) (
    input logic clk12_i,
    input logic rstN_i,

    // Receive stream
    input usbPePkg::rxStream_t rx_i,
    output logic rxAccept_o,

    // Transmit stream
    output usbPePkg::txStream_t tx_o,
    input logic txAccept_i,
    input logic txDoneSending_i,

    // Shared endpoint port
    output logic [usbPePkg::endpWidth-1:0] epSelect_o,
    output logic epTransStart_o,
    output logic epOutValid_o,
    output logic [7:0] epOutData_o,
    input logic epOutFull_i,
    input usbPePkg::epInByte_t epIn_i,
    output logic epInPop_o,
    input usbPePkg::epResponse_t epResp_i,
    output usbPePkg::transResult_t fillResult_o,
    output usbPePkg::transResult_t popResult_o
);

    // Capture to FSM
    usbPePkg::tokenInfo_t token;
    logic tokenValid;
    logic pktDone;
    logic pktGood;
    logic [usbPePkg::pidWidth-1:0] lastPid;
    logic useInternalBuf;

    // FSM to transmit
    logic sendingPhase;
    logic sendPid;
    logic pidIsLast;
    logic [usbPePkg::pidWidth-1:0] pid;

    assign epSelect_o = token.endp;

    usbTokenCapture #(
        .devAddr(devAddr),
        .epCount(epCount)
    ) tokenCapture (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .rx_i(rx_i),
        .rxAccept_o(rxAccept_o),
        .useInternalBuf_i(useInternalBuf),
        .epOutFull_i(epOutFull_i),
        .epOutValid_o(epOutValid_o),
        .epOutData_o(epOutData_o),
        .token_o(token),
        .tokenValid_o(tokenValid),
        .pktDone_o(pktDone),
        .pktGood_o(pktGood),
        .lastPid_o(lastPid)
    );

    usbTransactionFsm #(
        .responseTimeout(responseTimeout)
    ) transactionFsm (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .token_i(token),
        .tokenValid_i(tokenValid),
        .pktDone_i(pktDone),
        .pktGood_i(pktGood),
        .lastPid_i(lastPid),
        .epResp_i(epResp_i),
        .epInAvailable_i(epIn_i.available),
        .epTransStart_o(epTransStart_o),
        .fillResult_o(fillResult_o),
        .popResult_o(popResult_o),
        .txDoneSending_i(txDoneSending_i),
        .useInternalBuf_o(useInternalBuf),
        .sendingPhase_o(sendingPhase),
        .sendPid_o(sendPid),
        .pidIsLast_o(pidIsLast),
        .pid_o(pid)
    );

    usbTxSequencer #(
        .maxPacketSize(maxPacketSize)
    ) txSequencer (
        .clk12_i(clk12_i),
        .rstN_i(rstN_i),
        .sendingPhase_i(sendingPhase),
        .sendPid_i(sendPid),
        .pidIsLast_i(pidIsLast),
        .pid_i(pid),
        .epIn_i(epIn_i),
        .epInPop_o(epInPop_o),
        .txAccept_i(txAccept_i),
        .tx_o(tx_o)
    );

endmodule

`default_nettype wire

//--- verilog/usbTxSequencer.sv
`default_nettype none

module usbTxSequencer #(
    parameter int maxPacketSize = 64
) (
    input logic clk12_i,
    input logic rstN_i,

    // From the FSM
    input logic sendingPhase_i,
    input logic sendPid_i,
    input logic pidIsLast_i,
    input logic [usbPePkg::pidWidth-1:0] pid_i,

    // Endpoint IN data
    input usbPePkg::epInByte_t epIn_i,
    output logic epInPop_o,

    // Serializer side
    input logic txAccept_i,
    output usbPePkg::txStream_t tx_o
);

    localparam logic [usbPePkg::pktSizeWidth-1:0] maxBytes =
        usbPePkg::pktSizeWidth'(maxPacketSize);

    logic sendPrev;
    logic reqSendQ;
    // PID byte waits for the serializer
    logic pidPending;
    logic [usbPePkg::pidWidth-1:0] pidQ;
    logic pidLastQ;
    // Data bytes follow the PID
    logic streaming;
    logic [usbPePkg::pktSizeWidth-1:0] bytesLeft;
    logic txFire;

    // ======================================================================
    // Output stream
    // ======================================================================

    always_comb begin
        tx_o.reqSend = reqSendQ;
        tx_o.valid = pidPending || (streaming && epIn_i.available);
        // Last at the endpoint's end or when the packet size is used up
        tx_o.last = pidPending ? pidLastQ
            : (epIn_i.isLast || bytesLeft == usbPePkg::pktSizeWidth'(1));
        // Check nibble goes on top
        tx_o.data = pidPending ? {~pidQ, pidQ} : epIn_i.data;
    end

    assign txFire = tx_o.valid && txAccept_i;
    assign epInPop_o = txFire && !pidPending;

    // ======================================================================
    // Control
    // ======================================================================

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            sendPrev <= 1'b0;
            reqSendQ <= 1'b0;
            pidPending <= 1'b0;
            streaming <= 1'b0;
            bytesLeft <= '0;
        end else begin
            // Request pulse on the rising edge of the send phase
            sendPrev <= sendingPhase_i;
            reqSendQ <= sendingPhase_i && !sendPrev;

            if (pidPending) begin
                if (txFire) begin
                    pidPending <= 1'b0;
                    streaming <= !pidLastQ;
                    bytesLeft <= maxBytes;
                end
            end else if (sendPid_i) begin
                pidPending <= 1'b1;
            end else if (streaming && txFire) begin
                bytesLeft <= bytesLeft - 1'b1;
                if (tx_o.last) begin
                    streaming <= 1'b0;
                end
            end
        end
    end

    // PID held until it is sent
    always_ff @(posedge clk12_i) begin
        if (sendPid_i) begin
            pidQ <= pid_i;
            pidLastQ <= pidIsLast_i;
        end
    end

    // Offered byte stays until the serializer takes it
    validHeld: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        tx_o.valid && !txAccept_i |=> tx_o.valid);

endmodule

`default_nettype wire

//--- verilog/usbTransactionFsm.sv
`default_nettype none

module usbTransactionFsm #(
    parameter int responseTimeout = 200
) (
    input logic clk12_i,
    input logic rstN_i,

    // From the capture stage
    input usbPePkg::tokenInfo_t token_i,
    input logic tokenValid_i,
    input logic pktDone_i,
    input logic pktGood_i,
    input logic [usbPePkg::pidWidth-1:0] lastPid_i,

    // Endpoint side
    input usbPePkg::epResponse_t epResp_i,
    input logic epInAvailable_i,
    output logic epTransStart_o,
    output usbPePkg::transResult_t fillResult_o,
    output usbPePkg::transResult_t popResult_o,

    // Serializer finished the packet
    input logic txDoneSending_i,

    output logic useInternalBuf_o,

    // Towards the transmit stage
    output logic sendingPhase_o,
    output logic sendPid_o,
    output logic pidIsLast_o,
    output logic [usbPePkg::pidWidth-1:0] pid_o
);

    localparam int timerWidth = $clog2(responseTimeout + 1);

    typedef enum logic [2:0] {
        idle,
        // Bulk/interrupt OUT
        outHandle,
        outRespond,
        outWaitSent,
        // Bulk/interrupt IN
        inIssue,
        inWaitSent,
        inAwaitAck,
        finish
    } state_t;

    state_t state;
    state_t nextState;

    logic [timerWidth-1:0] timer;
    logic timerRun;
    logic timeout;
    // IN answered with a handshake, so no ACK phase follows
    logic inHandshake;

    // ======================================================================
    // Response timer
    // ======================================================================

    assign timerRun = state == outHandle || state == inAwaitAck;
    assign timeout = timerRun && timer == timerWidth'(responseTimeout);

    assign useInternalBuf_o = state == idle || state == inAwaitAck || state == finish;
    assign sendingPhase_o = state == outRespond || state == outWaitSent
        || state == inIssue || state == inWaitSent;

    // ======================================================================
    // Next state
    // ======================================================================

    always_comb begin
        nextState = state;
        sendPid_o = 1'b0;
        pidIsLast_o = 1'b1;
        // OUT only ever answers with a handshake
        pid_o = {epResp_i.pidUpper, usbPePkg::pidTypeHandshake};
        fillResult_o = '0;
        popResult_o = '0;

        case (state)
            idle: begin
                // Token is registered by now, branch on its direction
                if (epTransStart_o) begin
                    nextState = token_i.isIn ? inIssue : outHandle;
                end
            end
            outHandle: begin
                fillResult_o.done = pktDone_i || timeout;
                fillResult_o.success = pktDone_i && pktGood_i;
                if (pktDone_i) begin
                    // Broken data gets no answer at all
                    nextState = pktGood_i ? outRespond : finish;
                end else if (timeout) begin
                    nextState = finish;
                end
            end
            outRespond: begin
                sendPid_o = epResp_i.valid;
                if (epResp_i.valid) begin
                    nextState = outWaitSent;
                end
            end
            outWaitSent: begin
                if (txDoneSending_i) begin
                    nextState = finish;
                end
            end
            inIssue: begin
                sendPid_o = epResp_i.valid;
                // No data behind a DATA PID means a zero-length packet
                pidIsLast_o = epResp_i.isHandshake || !epInAvailable_i;
                pid_o = {epResp_i.pidUpper,
                    epResp_i.isHandshake ? usbPePkg::pidTypeHandshake : usbPePkg::pidTypeData};
                if (epResp_i.valid) begin
                    nextState = inWaitSent;
                end
            end
            inWaitSent: begin
                // NAK or STALL ends here, nothing was delivered
                popResult_o.done = txDoneSending_i && inHandshake;
                if (txDoneSending_i) begin
                    nextState = inHandshake ? finish : inAwaitAck;
                end
            end
            inAwaitAck: begin
                popResult_o.done = pktDone_i || timeout;
                popResult_o.success = pktDone_i && pktGood_i && lastPid_i == usbPePkg::pidAck;
                if (pktDone_i || timeout) begin
                    nextState = finish;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            state <= idle;
            epTransStart_o <= 1'b0;
            timer <= '0;
            inHandshake <= 1'b0;
        end else begin
            state <= nextState;
            epTransStart_o <= state == idle && tokenValid_i;
            timer <= timerRun ? timer + 1'b1 : '0;
            if (state == inIssue && epResp_i.valid) begin
                inHandshake <= epResp_i.isHandshake;
            end
        end
    end

    // Each result strobe belongs to the direction of the token in flight
    fillOnlyForOut: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        fillResult_o.done |-> token_i.pid != usbPePkg::pidIn);
    popOnlyForIn: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        popResult_o.done |-> token_i.isIn);

endmodule

`default_nettype wire

//--- verilog/usbTokenCapture.sv
`default_nettype none

module usbTokenCapture #(
    parameter logic [usbPePkg::devAddrWidth-1:0] devAddr = '0,
    parameter int epCount = 1
) (
    input logic clk12_i,
    input logic rstN_i,

    // Front end receive stream
    input usbPePkg::rxStream_t rx_i,
    output logic rxAccept_o,

    // From the FSM
    input logic useInternalBuf_i,

    // OUT data towards the endpoint
    input logic epOutFull_i,
    output logic epOutValid_o,
    output logic [7:0] epOutData_o,

    // Towards the FSM
    output usbPePkg::tokenInfo_t token_o,
    output logic tokenValid_o,
    output logic pktDone_o,
    output logic pktGood_o,
    output logic [usbPePkg::pidWidth-1:0] lastPid_o
);

    localparam logic [usbPePkg::endpWidth:0] epLimit = epCount[usbPePkg::endpWidth:0];

    // PID byte and the two token bytes
    logic [2:0][7:0] pktBuf;
    // Bytes of the current packet, saturates at 3
    logic [1:0] pktCnt;
    logic bufFull;
    logic rxFire;
    logic doneQ;
    logic keepQ;

    logic [usbPePkg::pidWidth-1:0] pidNow;
    logic [usbPePkg::devAddrWidth-1:0] addrNow;
    logic [usbPePkg::endpWidth-1:0] endpNow;
    logic pidCheckOk;
    logic isToken;

    // ======================================================================
    // Byte routing
    // ======================================================================

    assign bufFull = pktCnt == 2'd3;

    // Internal buffer never stalls, so foreign traffic drains quickly
    // The PID byte is always taken, only payload waits on the endpoint
    assign rxAccept_o = !doneQ && (useInternalBuf_i || pktCnt == 2'd0 || !epOutFull_i);
    assign rxFire = rx_i.valid && rxAccept_o;

    // Data PID stays here, the payload goes to the endpoint
    assign epOutValid_o = rxFire && !useInternalBuf_i && pktCnt != 2'd0;
    assign epOutData_o = rx_i.data;

    always_ff @(posedge clk12_i) begin
        if (!rstN_i) begin
            doneQ <= 1'b0;
            pktCnt <= 2'd0;
        end else begin
            // One cycle per packet end
            doneQ <= !doneQ && rx_i.done;
            if (doneQ) begin
                pktCnt <= 2'd0;
            end else if (rxFire && !bufFull) begin
                pktCnt <= pktCnt + 2'd1;
            end
        end
    end

    // Head bytes land in the buffer in both modes
    // so a data packet overwrites the old token PID
    always_ff @(posedge clk12_i) begin
        keepQ <= rx_i.keep;
        if (rxFire && !bufFull) begin
            pktBuf[pktCnt] <= rx_i.data;
        end
    end

    // ======================================================================
    // Token decode
    // ======================================================================

    assign pidNow = pktBuf[0][3:0];
    assign pidCheckOk = pktBuf[0][7:4] == ~pidNow;
    assign addrNow = pktBuf[1][6:0];
    // Endpoint straddles the two token bytes
    assign endpNow = {pktBuf[2][2:0], pktBuf[1][7]};

    // SOF shares the token class and is dropped here
    assign isToken = bufFull && pidCheckOk
        && pidNow[1:0] == usbPePkg::pidTypeToken
        && pidNow != usbPePkg::pidSof;

    assign tokenValid_o = doneQ && keepQ && isToken
        && addrNow == devAddr
        && {1'b0, endpNow} < epLimit;

    assign pktDone_o = doneQ;
    assign pktGood_o = keepQ;
    // Handshake from the host is one byte, read in the pktDone cycle
    assign lastPid_o = pidNow;

    // Token held for the whole transaction
    always_ff @(posedge clk12_i) begin
        if (tokenValid_o) begin
            token_o.pid <= pidNow;
            token_o.endp <= endpNow;
            token_o.isIn <= pidNow == usbPePkg::pidIn;
        end
    end

    // Tokens only start a transaction while the FSM listens on the buffer
    tokenOnlyWhenListening: assert property (@(posedge clk12_i) disable iff (!rstN_i)
        tokenValid_o |-> useInternalBuf_i);

endmodule

`default_nettype wire

//--- verilog/usbPePkg.sv
`default_nettype none

package usbPePkg;

    // ======================================================================
    // Field widths
    // ======================================================================

    localparam int pidWidth = 4;
    localparam int devAddrWidth = 7;
    localparam int endpWidth = 4;
    // Counts data bytes of one packet, up to 1023
    localparam int pktSizeWidth = 11;

    // ======================================================================
    // PID codes
    // ======================================================================

    // Token PIDs
    localparam logic [pidWidth-1:0] pidOut = 4'b0001;
    localparam logic [pidWidth-1:0] pidIn = 4'b1001;
    localparam logic [pidWidth-1:0] pidSetup = 4'b1101;
    localparam logic [pidWidth-1:0] pidSof = 4'b0101;
    // Handshake PIDs
    localparam logic [pidWidth-1:0] pidAck = 4'b0010;
    localparam logic [pidWidth-1:0] pidNak = 4'b1010;
    localparam logic [pidWidth-1:0] pidStall = 4'b1110;
    // Data PIDs
    localparam logic [pidWidth-1:0] pidData0 = 4'b0011;
    localparam logic [pidWidth-1:0] pidData1 = 4'b1011;

    // Packet class sits in the two low PID bits
    localparam logic [1:0] pidTypeToken = 2'b01;
    localparam logic [1:0] pidTypeHandshake = 2'b10;
    localparam logic [1:0] pidTypeData = 2'b11;

    // ======================================================================
    // Streams and stage records
    // ======================================================================

    // Receive bytes from the serial front end
    typedef struct packed {
        logic [7:0] data;
        logic valid;
        // Strobe after the last byte of a packet
        logic done;
        // Good CRC and no dropped byte, valid with done
        logic keep;
    } rxStream_t;

    // Transmit bytes towards the serializer
    typedef struct packed {
        logic reqSend;
        logic valid;
        logic last;
        logic [7:0] data;
    } txStream_t;

    // Token that passed all checks
    typedef struct packed {
        logic [pidWidth-1:0] pid;
        logic [endpWidth-1:0] endp;
        logic isIn;
    } tokenInfo_t;

    // Endpoint answer to a transaction
    typedef struct packed {
        logic valid;
        logic isHandshake;
        // PID bits 3:2, the class bits are added by the engine
        logic [1:0] pidUpper;
    } epResponse_t;

    // Head of the endpoint IN buffer
    typedef struct packed {
        logic [7:0] data;
        logic available;
        logic isLast;
    } epInByte_t;

    // Transaction end strobe
    typedef struct packed {
        logic done;
        logic success;
    } transResult_t;

endpackage

`default_nettype wire
